/* all.f */
hw/isa_pkg.sv
hw/core_pkg.sv
hw/dmem_if.sv
hw/decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/fetch_unit.sv
hw/mem_access.sv
hw/cpu_top.sv
+incdir+bench
bench/tb_cpu.sv

/* bench/tb_tasks.svh */
task automatic check_word(input string name, input word_t expected, input word_t actual);
  if (expected !== actual)
    abort_run($sformatf("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual));
endtask

task automatic check_addr(input string name, input word_t expected, input word_t actual);
  if (expected !== actual)
    abort_run($sformatf("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual));
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
  if (expected !== actual)
    abort_run($sformatf("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual));
endtask

function automatic word_t cur_pc();
  return 32'(prog.size() * 4);
endfunction

task automatic emit(input instr_t instr);
  prog.push_back(instr);
endtask

// store to the next result slot, then remember what it should hold
task automatic emit_store(input reg_addr_t r, input word_t expected);
  emit(enc_s(12'(STORE_BASE + 32'(4 * exp_q.size())), r, 5'd0));
  exp_q.push_back(expected);
endtask

task automatic emit_end();
  emit(enc_s(12'(SENTINEL), 5'd0, 5'd0));
  emit(enc_j(21'd0, 5'd0)); // spin
endtask

task automatic check_stores();
  if (st_data.size() != exp_q.size())
    abort_run($sformatf("saw %0d stores, expected %0d", st_data.size(), exp_q.size()));
  foreach (exp_q[i]) begin
    check_addr("dmem_addr", STORE_BASE + 32'(4 * i), st_addr[i]);
    check_word("dmem_wdata", exp_q[i], st_data[i]);
  end
endtask

function automatic word_t less_than(word_t va, word_t vb, logic uns);
  return uns ? {31'd0, va < vb} : {31'd0, $signed(va) < $signed(vb)};
endfunction

function automatic logic branch_taken(funct3_t f3, word_t va, word_t vb);
  case (f3)
    F3_BEQ:  return va == vb;
    F3_BNE:  return va != vb;
    F3_BLT:  return $signed(va) < $signed(vb);
    F3_BGE:  return $signed(va) >= $signed(vb);
    F3_BLTU: return va < vb;
    default: return va >= vb;
  endcase
endfunction

task automatic check_next_pc(input word_t at, input word_t expected);
  logic found;
  found = 1'b0;
  for (int i = 0; i + 1 < pc_log.size(); i++) begin
    if (!found && pc_log[i] == at) begin
      found = 1'b1;
      check_addr("imem_addr", expected, pc_log[i+1]);
    end
  end
  if (!found)
    abort_run($sformatf("pc %h never fetched", at));
endtask

task automatic test_reset();
  start_test();
  // nonzero registers for the reset to clear
  emit(enc_i(12'h5a5, 5'd0, F3_ADD, 5'd1, OP_IMM));
  emit(enc_i(12'h3c3, 5'd0, F3_ADD, 5'd15, OP_IMM));
  emit(enc_i(12'h7ff, 5'd0, F3_ADD, 5'd31, OP_IMM));
  emit_store(5'd1, 32'h0000_05a5);
  emit_store(5'd15, 32'h0000_03c3);
  emit_store(5'd31, 32'h0000_07ff);
  emit_end();
  run_program();
  check_stores();
  start_test();
  emit(NOP_INSTR);
  emit_store(5'd1, '0);
  emit_store(5'd15, '0);
  emit_store(5'd31, '0);
  emit_end();
  load_imem();
  apply_reset();
  check_addr("imem_addr", '0, imem_addr);
  check_bit("dmem_we", 1'b0, dmem_we);
  check_bit("dmem_re", 1'b0, dmem_re);
  wait_sentinel();
  check_stores();
endtask

task automatic test_alu();
  word_t       a;
  word_t       b;
  word_t       simm;
  logic [11:0] imm12;
  logic [19:0] up;
  logic [4:0]  sh;
  start_test();
  a     = $urandom;
  b     = $urandom;
  imm12 = 12'($urandom);
  up    = 20'($urandom);
  sh    = 5'($urandom);
  simm  = {{20{imm12[11]}}, imm12};
  dmem_image[0] = a;
  dmem_image[1] = b;
  emit(enc_i(12'd0, 5'd0, F3_WORD, 5'd1, LOAD));
  emit(enc_i(12'd4, 5'd0, F3_WORD, 5'd2, LOAD));
  emit(enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd3, OP));
  emit_store(5'd3, a + b);
  emit(enc_r(F7_ALT, 5'd2, 5'd1, F3_ADD, 5'd3, OP));
  emit_store(5'd3, a - b);
  emit(enc_r(F7_BASE, 5'd2, 5'd1, F3_AND, 5'd3, OP));
  emit_store(5'd3, a & b);
  emit(enc_r(F7_BASE, 5'd2, 5'd1, F3_OR, 5'd3, OP));
  emit_store(5'd3, a | b);
  emit(enc_r(F7_BASE, 5'd2, 5'd1, F3_XOR, 5'd3, OP));
  emit_store(5'd3, a ^ b);
  emit(enc_r(F7_BASE, 5'd2, 5'd1, F3_SLL, 5'd3, OP));
  emit_store(5'd3, a << b[4:0]);
  emit(enc_r(F7_BASE, 5'd2, 5'd1, F3_SRL, 5'd3, OP));
  emit_store(5'd3, a >> b[4:0]);
  emit(enc_r(F7_ALT, 5'd2, 5'd1, F3_SRL, 5'd3, OP));
  emit_store(5'd3, word_t'($signed(a) >>> b[4:0]));
  emit(enc_i(imm12, 5'd1, F3_ADD, 5'd4, OP_IMM));
  emit_store(5'd4, a + simm);
  emit(enc_i(imm12, 5'd1, F3_AND, 5'd4, OP_IMM));
  emit_store(5'd4, a & simm);
  emit(enc_i(imm12, 5'd1, F3_OR, 5'd4, OP_IMM));
  emit_store(5'd4, a | simm);
  emit(enc_i(imm12, 5'd1, F3_XOR, 5'd4, OP_IMM));
  emit_store(5'd4, a ^ simm);
  emit(enc_i({7'b0000000, sh}, 5'd1, F3_SLL, 5'd4, OP_IMM));
  emit_store(5'd4, a << sh);
  emit(enc_i({7'b0000000, sh}, 5'd1, F3_SRL, 5'd4, OP_IMM));
  emit_store(5'd4, a >> sh);
  emit(enc_i({7'b0100000, sh}, 5'd1, F3_SRL, 5'd4, OP_IMM)); // srai
  emit_store(5'd4, word_t'($signed(a) >>> sh));
  emit({up, 5'd6, LUI});
  emit_store(5'd6, {up, 12'd0});
  emit(enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd0, OP));
  emit_store(5'd0, '0);
  emit_end();
  run_program();
  check_stores();
endtask

task automatic cmp_r(input reg_addr_t r1, input reg_addr_t r2, input logic uns,
                     input word_t va, input word_t vb);
  emit(enc_r(F7_BASE, r2, r1, uns ? F3_SLTU : F3_SLT, 5'd5, OP));
  emit_store(5'd5, less_than(va, vb, uns));
endtask

task automatic cmp_i(input reg_addr_t r1, input logic [11:0] imm, input logic uns,
                     input word_t va);
  emit(enc_i(imm, r1, uns ? F3_SLTU : F3_SLT, 5'd5, OP_IMM));
  emit_store(5'd5, less_than(va, {{20{imm[11]}}, imm}, uns));
endtask

task automatic test_compare();
  word_t v [4];
  start_test();
  v = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0001};
  for (int i = 0; i < 4; i++) begin
    dmem_image[i] = v[i];
    emit(enc_i(12'(4 * i), 5'd0, F3_WORD, 5'(i + 1), LOAD));
  end
  cmp_r(5'd1, 5'd2, 1'b0, v[0], v[1]);
  cmp_r(5'd2, 5'd1, 1'b0, v[1], v[0]);
  cmp_r(5'd1, 5'd1, 1'b0, v[0], v[0]);
  cmp_r(5'd1, 5'd2, 1'b1, v[0], v[1]);
  cmp_r(5'd3, 5'd4, 1'b1, v[2], v[3]);
  cmp_r(5'd4, 5'd3, 1'b1, v[3], v[2]);
  cmp_r(5'd3, 5'd3, 1'b1, v[2], v[2]);
  cmp_i(5'd1, 12'hfff, 1'b0, v[0]);
  cmp_i(5'd3, 12'hfff, 1'b0, v[2]); // equal
  cmp_i(5'd2, 12'h000, 1'b0, v[1]);
  cmp_i(5'd4, 12'hfff, 1'b1, v[3]);
  cmp_i(5'd3, 12'hfff, 1'b1, v[2]);
  cmp_i(5'd4, 12'h001, 1'b1, v[3]);
  emit_end();
  run_program();
  check_stores();
endtask

task automatic test_latency();
  word_t loaded;
  word_t addend;
  word_t exp_pc [7];
  start_test();
  loaded = $urandom;
  addend = $urandom & 32'h0000_07ff;
  dmem_image[0] = loaded;
  emit(enc_i(12'd0, 5'd0, F3_WORD, 5'd1, LOAD));
  emit(enc_i(12'(addend), 5'd0, F3_ADD, 5'd2, OP_IMM));
  emit(enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd3, OP));
  emit_store(5'd3, loaded + addend);
  emit_end();
  run_program();
  check_stores();
  check_word("dmem_re cycles", 32'd1, word_t'(re_cycles));
  exp_pc = '{32'd0, 32'd0, 32'd4, 32'd8, 32'd12, 32'd12, 32'd16}; // load and store hold 2
  if (pc_log.size() < 7)
    abort_run("pc trace too short");
  foreach (exp_pc[i])
    check_addr("imem_addr", exp_pc[i], pc_log[i]);
endtask

task automatic br_case(input funct3_t f3, input reg_addr_t r1, input reg_addr_t r2,
                       input word_t va, input word_t vb);
  word_t p;
  p = cur_pc();
  emit(enc_b(13'd8, r2, r1, f3));
  emit(NOP_INSTR);
  br_at.push_back(p);
  br_next.push_back(branch_taken(f3, va, vb) ? p + 32'd8 : p + 32'd4);
endtask

task automatic test_control();
  word_t x1;
  word_t x2;
  word_t p;
  word_t q;
  funct3_t f3s [6];
  start_test();
  x1  = 32'd5;
  x2  = 32'hffff_fffd;
  f3s = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
  emit(enc_i(12'(x1), 5'd0, F3_ADD, 5'd1, OP_IMM));
  emit(enc_i(12'(x2), 5'd0, F3_ADD, 5'd2, OP_IMM));
  foreach (f3s[i]) begin
    br_case(f3s[i], 5'd1, 5'd2, x1, x2);
    br_case(f3s[i], 5'd2, 5'd1, x2, x1);
    br_case(f3s[i], 5'd1, 5'd1, x1, x1);
  end
  p = cur_pc();
  emit(enc_j(21'd12, 5'd5));
  emit(NOP_INSTR);
  emit(NOP_INSTR);
  emit_store(5'd5, p + 32'd4);
  br_at.push_back(p);
  br_next.push_back(p + 32'd12);
  q = cur_pc() + 32'd4;
  emit(enc_i(12'(q + 32'd13), 5'd0, F3_ADD, 5'd6, OP_IMM)); // bit 0 of the odd target dropped
  emit(enc_i(12'd0, 5'd6, F3_JALR, 5'd7, JALR));
  emit(NOP_INSTR);
  emit(NOP_INSTR);
  emit_store(5'd7, q + 32'd4);
  br_at.push_back(q);
  br_next.push_back(q + 32'd12);
  emit_end();
  run_program();
  check_stores();
  foreach (br_at[i])
    check_next_pc(br_at[i], br_next[i]);
endtask

/* bench/tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu;
  import isa_pkg::*;
  import core_pkg::*;

  localparam int    CLK_PERIOD      = 10;
  localparam int    NUM_TESTS       = 5;
  localparam int    CYCLES_PER_TEST = 200;
  localparam word_t SENTINEL        = 32'h0000_07fc; // end-of-program store
  localparam word_t STORE_BASE      = 32'h0000_0100;

  logic   clk = 1'b0;
  logic   rst = 1'b1;
  word_t  imem_addr;
  instr_t imem_data;
  word_t  dmem_addr;
  word_t  dmem_wdata;
  logic   dmem_we;
  logic   dmem_re;
  word_t  dmem_rdata = '0;

  instr_t imem [256];
  word_t  dmem [512];
  word_t  dmem_image [512]; // loaded into dmem while in reset

  instr_t prog [$];
  word_t  exp_q [$];
  word_t  br_at [$];
  word_t  br_next [$];
  word_t  pc_log [$];
  word_t  st_addr [$];
  word_t  st_data [$];
  logic   done = 1'b0;
  int     re_cycles = 0;

  cpu_top #(.RESET_PC('0)) dut_i (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
    .dmem_re(dmem_re), .dmem_rdata(dmem_rdata)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  assign imem_data = imem[imem_addr[9:2]]; // combinational fetch

  // data memory with one-cycle registered read
  always @(posedge clk) begin
    if (rst) begin
      dmem       <= dmem_image;
      dmem_rdata <= '0;
    end else begin
      if (dmem_we)
        dmem[dmem_addr[10:2]] <= dmem_wdata;
      if (dmem_re)
        dmem_rdata <= dmem[dmem_addr[10:2]];
    end
  end

  // pc trace and store log
  always @(posedge clk) begin
    if (rst) begin
      pc_log.delete();
      st_addr.delete();
      st_data.delete();
      done      = 1'b0;
      re_cycles = 0;
    end else begin
      pc_log.push_back(imem_addr);
      if (dmem_re)
        re_cycles++;
      if (dmem_we && dmem_addr == SENTINEL) begin
        done = 1'b1;
      end else if (dmem_we) begin
        st_addr.push_back(dmem_addr);
        st_data.push_back(dmem_wdata);
      end
    end
  end

  function automatic instr_t enc_r(funct7_t f7, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3,
                                   reg_addr_t rd, opcode_e op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic instr_t enc_i(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                   reg_addr_t rd, opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instr_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], STORE};
  endfunction

  function automatic instr_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                   funct3_t f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
  endfunction

  function automatic instr_t enc_j(logic [20:0] off, reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic start_test();
    prog.delete();
    exp_q.delete();
    br_at.delete();
    br_next.delete();
    for (int i = 0; i < 256; i++)
      imem[i] = {12'(i), 5'd0, 3'b000, 5'd0, OP_IMM}; // addi x0,x0,index
    for (int i = 0; i < 512; i++)
      dmem_image[i] = 32'hda7a_0000 | word_t'(i);
  endtask

  task automatic load_imem();
    foreach (prog[i])
      imem[i] = prog[i];
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic wait_sentinel();
    int n;
    n = 0;
    while (!done) begin
      @(negedge clk);
      n++;
      if (n > CYCLES_PER_TEST)
        abort_run("program never reached its end store");
    end
  endtask

  task automatic run_program();
    load_imem();
    apply_reset();
    wait_sentinel();
  endtask

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    abort_run("watchdog expired before the tests finished");
  end

  `include "tb_tasks.svh"

  initial begin
    void'($urandom(66));
    start_test();
    test_reset();
    test_alu();
    test_compare();
    test_latency();
    test_control();
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ns

module alu (
  input  core_pkg::word_t a,
  input  core_pkg::word_t b_reg,
  input  core_pkg::word_t imm,
  input  core_pkg::ctrl_t ctrl,
  output core_pkg::word_t result,
  output logic            lt,
  output logic            take_branch
);
  import core_pkg::*;

  word_t      b;
  logic [4:0] shamt;
  logic       eq;

  assign b     = ctrl.use_imm ? imm : b_reg;
  assign shamt = b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      FOP_ADD: result = a + b;
      FOP_SUB: result = a - b;
      FOP_SLL: result = a << shamt;
      FOP_SRL: result = a >> shamt;
      FOP_SRA: result = word_t'($signed(a) >>> shamt);
      FOP_AND: result = a & b;
      FOP_OR:  result = a | b;
      FOP_XOR: result = a ^ b;
      FOP_IMM: result = imm;
      default: result = '0;
    endcase
  end

  // compare straight on the operands, no flag tricks
  assign eq = (a == b);
  assign lt = ctrl.is_unsigned ? (a < b) : ($signed(a) < $signed(b));

  always_comb begin
    case (ctrl.branch)
      BEQ:        take_branch = eq;
      BNE:        take_branch = !eq;
      BLT, BLTU:  take_branch = lt;
      BGE, BGEU:  take_branch = !lt;
      JMP:        take_branch = 1'b1;
      default:    take_branch = 1'b0;
    endcase
  end

endmodule

/* hw/core_pkg.sv */
package core_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  typedef enum logic [3:0] {
    FOP_ADD = 4'd0,
    FOP_SUB = 4'd1,
    FOP_SLL = 4'd2,
    FOP_SRL = 4'd3,
    FOP_SRA = 4'd4,
    FOP_AND = 4'd5,
    FOP_OR  = 4'd6,
    FOP_XOR = 4'd7,
    FOP_IMM = 4'd8  // pass immediate, lui
  } alu_op_e;

  typedef enum logic [2:0] {
    NONE = 3'd0,
    BEQ  = 3'd1,
    BNE  = 3'd2,
    BLT  = 3'd3,
    BGE  = 3'd4,
    BLTU = 3'd5,
    BGEU = 3'd6,
    JMP  = 3'd7
  } branch_e;

  // writeback source
  typedef enum logic [1:0] {
    ALU = 2'd0,
    MEM = 2'd1,
    SLT = 2'd2,
    PC4 = 2'd3
  } wb_sel_e;

  typedef struct packed {
    alu_op_e alu_op;
    branch_e branch;
    logic    use_imm;
    logic    is_unsigned;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    wb_sel_e wb_sel;
    logic    jump_reg;    // jalr target from rs1
  } ctrl_t;

endpackage

/* hw/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top #(
  parameter core_pkg::word_t RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  output core_pkg::word_t imem_addr,
  input  isa_pkg::instr_t imem_data,
  output core_pkg::word_t dmem_addr,
  output core_pkg::word_t dmem_wdata,
  output logic            dmem_we,
  output logic            dmem_re,
  input  core_pkg::word_t dmem_rdata
);
  import isa_pkg::*;
  import core_pkg::*;

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm;
  ctrl_t     ctrl;
  word_t     rs1_val;
  word_t     rs2_val;
  word_t     alu_result;
  logic      lt;
  logic      take_branch;
  logic      pc_hold;
  logic      rd_we;
  word_t     rd_data;
  word_t     pc_plus4;

  dmem_if dmem_bus ();

  // data port out to the pins
  assign dmem_addr      = dmem_bus.addr;
  assign dmem_wdata     = dmem_bus.wdata;
  assign dmem_we        = dmem_bus.we;
  assign dmem_re        = dmem_bus.re;
  assign dmem_bus.rdata = dmem_rdata;

  fetch_unit #(.RESET_PC(RESET_PC)) fetch_i (
    .clk(clk), .rst(rst), .imm(imm), .rs1_val(rs1_val),
    .take_branch(take_branch), .jump_reg(ctrl.jump_reg), .pc_hold(pc_hold),
    .pc(imem_addr), .pc_plus4(pc_plus4)
  );

  decoder decoder_i (
    .instr(imem_data), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .ctrl(ctrl)
  );

  reg_file reg_file_i (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
    .we(rd_we), .wdata(rd_data), .rs1_val(rs1_val), .rs2_val(rs2_val)
  );

  alu alu_i (
    .a(rs1_val), .b_reg(rs2_val), .imm(imm), .ctrl(ctrl),
    .result(alu_result), .lt(lt), .take_branch(take_branch)
  );

  mem_access mem_i (
    .clk(clk), .rst(rst), .ctrl(ctrl), .alu_result(alu_result), .lt(lt),
    .store_data(rs2_val), .pc_plus4(pc_plus4), .dmem(dmem_bus.master),
    .pc_hold(pc_hold), .rd_we(rd_we), .rd_data(rd_data)
  );

endmodule

/* hw/decoder.sv */
`timescale 1ns/1ns

module decoder (
  input  isa_pkg::instr_t    instr,
  output isa_pkg::reg_addr_t rs1,
  output isa_pkg::reg_addr_t rs2,
  output isa_pkg::reg_addr_t rd,
  output core_pkg::word_t    imm,
  output core_pkg::ctrl_t    ctrl
);
  import isa_pkg::*;
  import core_pkg::*;

  opcode_e opcode;
  funct3_t funct3;
  funct7_t funct7;
  logic    alt;
  logic    f7_ok;
  logic    imm_f7_ok;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  assign alt = (funct7 == F7_ALT);
  // only add/sub and the right shifts have a second form
  assign f7_ok = (funct7 == F7_BASE) || (alt && (funct3 == F3_ADD || funct3 == F3_SRL));
  // immediate ops carry funct7 in the shift forms only
  assign imm_f7_ok = (funct3 == F3_SLL) ? (funct7 == F7_BASE) :
                     (funct3 == F3_SRL) ? (funct7 == F7_BASE || alt) : 1'b1;

  function automatic alu_op_e alu_fn(funct3_t f3, logic second);
    alu_op_e op;
    case (f3)
      F3_ADD:  op = second ? FOP_SUB : FOP_ADD;
      F3_SLL:  op = FOP_SLL;
      F3_XOR:  op = FOP_XOR;
      F3_SRL:  op = second ? FOP_SRA : FOP_SRL;
      F3_OR:   op = FOP_OR;
      F3_AND:  op = FOP_AND;
      default: op = FOP_SUB; // slt and sltu use lt
    endcase
    return op;
  endfunction

  always_comb begin
    case (opcode)
      OP_IMM, LOAD, JALR: imm = {{20{instr[31]}}, instr[31:20]};
      STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      LUI:    imm = {instr[31:12], 12'd0};
      JAL:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  always_comb begin
    // safe default: no writes, no branch
    ctrl.alu_op      = FOP_ADD;
    ctrl.branch      = NONE;
    ctrl.use_imm     = 1'b0;
    ctrl.is_unsigned = 1'b0;
    ctrl.reg_write   = 1'b0;
    ctrl.mem_read    = 1'b0;
    ctrl.mem_write   = 1'b0;
    ctrl.wb_sel      = ALU;
    ctrl.jump_reg    = 1'b0;
    case (opcode)
      OP, OP_IMM: begin
        if (opcode == OP ? f7_ok : imm_f7_ok) begin
          // addi has no sub form
          ctrl.alu_op      = alu_fn(funct3, alt && (opcode == OP || funct3 == F3_SRL));
          ctrl.use_imm     = (opcode == OP_IMM);
          ctrl.reg_write   = 1'b1;
          ctrl.is_unsigned = (funct3 == F3_SLTU);
          if (funct3 == F3_SLT || funct3 == F3_SLTU)
            ctrl.wb_sel = SLT;
        end
      end
      LOAD: begin
        if (funct3 == F3_WORD) begin
          ctrl.use_imm   = 1'b1;
          ctrl.mem_read  = 1'b1;
          ctrl.reg_write = 1'b1;
          ctrl.wb_sel    = MEM;
        end
      end
      STORE: begin
        if (funct3 == F3_WORD) begin
          ctrl.use_imm   = 1'b1;
          ctrl.mem_write = 1'b1;
        end
      end
      BRANCH: begin
        ctrl.alu_op = FOP_SUB;
        case (funct3)
          F3_BEQ:  ctrl.branch = BEQ;
          F3_BNE:  ctrl.branch = BNE;
          F3_BLT:  ctrl.branch = BLT;
          F3_BGE:  ctrl.branch = BGE;
          F3_BLTU: ctrl.branch = BLTU;
          F3_BGEU: ctrl.branch = BGEU;
          default: ctrl.branch = NONE;
        endcase
        ctrl.is_unsigned = (funct3 == F3_BLTU || funct3 == F3_BGEU);
      end
      LUI: begin
        ctrl.alu_op    = FOP_IMM;
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      JAL: begin
        ctrl.branch    = JMP;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = PC4;
      end
      JALR: begin
        if (funct3 == F3_JALR) begin
          ctrl.branch    = JMP;
          ctrl.jump_reg  = 1'b1;
          ctrl.reg_write = 1'b1;
          ctrl.wb_sel    = PC4;
        end
      end
      default: ;
    endcase
  end

endmodule

/* hw/dmem_if.sv */
`timescale 1ns/1ns

interface dmem_if;
  import core_pkg::*;

  word_t addr;
  word_t wdata;
  logic  we;
  logic  re;
  word_t rdata; // valid the cycle after re

  modport master (
    output addr, wdata, we, re,
    input  rdata
  );

  modport slave (
    input  addr, wdata, we, re,
    output rdata
  );

endinterface

/* hw/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit #(
  parameter core_pkg::word_t RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  core_pkg::word_t imm,
  input  core_pkg::word_t rs1_val,
  input  logic            take_branch,
  input  logic            jump_reg,
  input  logic            pc_hold,
  output core_pkg::word_t pc,
  output core_pkg::word_t pc_plus4
);
  import core_pkg::*;

  word_t target;
  word_t reg_target;
  word_t next_pc;

  assign pc_plus4   = pc + 32'd4;
  assign reg_target = rs1_val + imm;
  // jalr clears bit 0
  assign target  = jump_reg ? {reg_target[XLEN-1:1], 1'b0} : pc + imm;
  assign next_pc = take_branch ? target : pc_plus4;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (!pc_hold) begin
      pc <= next_pc;
    end
  end

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

  localparam int INSTR_W    = 32;
  localparam int OPCODE_W   = 7;
  localparam int REG_ADDR_W = 5;
  localparam int FUNCT3_W   = 3;
  localparam int FUNCT7_W   = 7;

  typedef logic [INSTR_W-1:0]    instr_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [FUNCT3_W-1:0]   funct3_t;
  typedef logic [FUNCT7_W-1:0]   funct7_t;

  // major opcodes of the supported subset
  typedef enum logic [OPCODE_W-1:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    LUI    = 7'b0110111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111
  } opcode_e;

  // alu funct3
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SRL  = 3'b101; // srl and sra
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam funct3_t F3_WORD = 3'b010; // lw / sw
  localparam funct3_t F3_JALR = 3'b000;

  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000; // sub, sra

  localparam instr_t NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

endpackage

/* hw/mem_access.sv */
`timescale 1ns/1ns

module mem_access (
  input  logic            clk,
  input  logic            rst,
  input  core_pkg::ctrl_t ctrl,
  input  core_pkg::word_t alu_result,
  input  logic            lt,
  input  core_pkg::word_t store_data,
  input  core_pkg::word_t pc_plus4,
  dmem_if.master          dmem,
  output logic            pc_hold,
  output logic            rd_we,
  output core_pkg::word_t rd_data
);
  import core_pkg::*;

  typedef enum logic {IDLE, WAIT} state_e;

  state_e state;
  state_e next_state;
  logic   is_mem;

  assign is_mem = ctrl.mem_read | ctrl.mem_write;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    pc_hold    = 1'b0;
    case (state)
      IDLE: begin
        if (is_mem) begin
          pc_hold    = 1'b1; // one extra cycle for the data port
          next_state = WAIT;
        end
      end
      WAIT: next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  // request only in the first cycle
  assign dmem.addr  = alu_result;
  assign dmem.wdata = store_data;
  assign dmem.re    = (state == IDLE) && ctrl.mem_read;
  assign dmem.we    = (state == IDLE) && ctrl.mem_write;

  // loads write back once rdata has arrived
  assign rd_we = ctrl.reg_write && (!ctrl.mem_read || state == WAIT);

  always_comb begin
    case (ctrl.wb_sel)
      MEM:     rd_data = dmem.rdata;
      SLT:     rd_data = {{(XLEN-1){1'b0}}, lt};
      PC4:     rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
  input  logic               clk,
  input  logic               rst,
  input  isa_pkg::reg_addr_t rs1,
  input  isa_pkg::reg_addr_t rs2,
  input  isa_pkg::reg_addr_t rd,
  input  logic               we,
  input  core_pkg::word_t    wdata,
  output core_pkg::word_t    rs1_val,
  output core_pkg::word_t    rs2_val
);
  import core_pkg::*;

  word_t regs [32];

  assign rs1_val = regs[rs1];
  assign rs2_val = regs[rs2];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (we && rd != '0) begin // x0 stays zero
      regs[rd] <= wdata;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build the cpu testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -f all.f --top-module tb_cpu -o tb_cpu > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_cpu > sim.log 2>&1
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "PASS: all tests" sim.log && echo "simulation passed" \
  || { echo "simulation ended without a result, see sim.log"; exit 1; }
